// File: source/gamePkg.sv
// Shared types for the shooter game logic
// Coordinate, colour and object state structs, missile phase enum
// Screen geometry, object sizes and colour constants
package gamePkg;

    typedef logic [9:0]  coordT;     // Pixel coordinate
    typedef logic [10:0] offsetT;    // Scroll offset

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } colorT;

    typedef struct packed {
        coordT x;
        coordT y;
    } posT;

    typedef enum logic [1:0] {
        missileIdle      = 2'd0,
        missileFlying    = 2'd1,
        missileExploding = 2'd2,
        missileSpent     = 2'd3
    } missilePhaseT;

    typedef struct packed {
        posT          pos;
        missilePhaseT phase;
    } missileStateT;

    typedef struct packed {
        posT  pos;
        logic fired;
    } bulletStateT;

    //////////////////////////////////////////////////////////////////////
    // Geometry
    //////////////////////////////////////////////////////////////////////
    localparam coordT screenWidth   = 10'd640;
    localparam coordT screenHeight  = 10'd480;

    localparam coordT playerWidth   = 10'd50;
    localparam coordT playerHeight  = 10'd100;
    localparam coordT missileWidth  = 10'd100;
    localparam coordT missileHeight = 10'd50;
    localparam coordT bulletSize    = 10'd5;

    // Banner band rows, bottom row excluded
    localparam coordT bannerTop     = 10'd100;
    localparam coordT bannerBottom  = 10'd200;

    //////////////////////////////////////////////////////////////////////
    // Palette
    //////////////////////////////////////////////////////////////////////
    localparam colorT skyColor     = '{4'hD, 4'hD, 4'hB};
    localparam colorT playerColor  = '{4'hF, 4'hE, 4'hB};    // Skin tone
    localparam colorT bulletColor  = '{4'hF, 4'hD, 4'h0};
    localparam colorT missileColor = '{4'hC, 4'hD, 4'hD};    // Metal grey
    localparam colorT explodeColor = '{4'hF, 4'h6, 4'h0};    // Flame orange
    localparam colorT startColor   = '{4'hF, 4'h0, 4'h0};
    localparam colorT endColor     = '{4'h0, 4'h0, 4'hF};
    localparam colorT blackColor   = '{4'h0, 4'h0, 4'h0};

endpackage

// File: source/gameControl.sv
// Scroll offset counter and sticky game-over flag
// Decodes the offset into per-missile launch strobes and windows
module gameControl
    import gamePkg::*;
#(
    parameter int scrollStep    = 4,
    parameter int scrollWrap    = 1280,
    parameter int missileWindow = 640,
    parameter int launchOffsetA = 0,
    parameter int launchOffsetB = 640
) (
    input  logic clk,
    input  logic rstN,
    input  logic start,
    input  logic hitPlayerA,
    input  logic hitPlayerB,
    output logic launchA,
    output logic launchB,
    output logic windowA,
    output logic windowB,
    output logic gameOver
);

    localparam offsetT stepValue = offsetT'(scrollStep);
    localparam offsetT wrapValue = offsetT'(scrollWrap);
    localparam offsetT beginA    = offsetT'(launchOffsetA);
    localparam offsetT endA      = offsetT'(launchOffsetA + missileWindow);
    localparam offsetT beginB    = offsetT'(launchOffsetB);
    localparam offsetT endB      = offsetT'(launchOffsetB + missileWindow);

    offsetT offset;

    // Runs every cycle, the game step
    always_ff @(posedge clk) begin
        if (!rstN) begin
            offset <= '0;
        end else if (offset >= wrapValue) begin
            offset <= '0;
        end else begin
            offset <= offset + stepValue;
        end
    end

    assign launchA = (offset == beginA);
    assign launchB = (offset == beginB);
    assign windowA = (offset >= beginA) && (offset < endA);    // Missile A active span
    assign windowB = (offset >= beginB) && (offset < endB);

    //////////////////////////////////////////////////////////////////////
    // Game over, held until start drops
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstN) begin
            gameOver <= 1'b0;
        end else if (!start) begin
            gameOver <= 1'b0;
        end else if (hitPlayerA || hitPlayerB) begin
            gameOver <= 1'b1;
        end
    end

endmodule

// File: source/bulletUnit.sv
// Bullet fire, rightward travel and re-arm at end of life or screen edge
module bulletUnit
    import gamePkg::*;
#(
    parameter int bulletSpeed = 20,
    parameter int bulletLife  = 60
) (
    input  logic        clk,
    input  logic        rstN,
    input  logic        fire,
    input  posT         playerPos,
    output bulletStateT bullet
);

    localparam int    lifeWidth  = $clog2(bulletLife + 1);
    localparam coordT gunOffsetX = 10'd20;    // Muzzle relative to player corner
    localparam coordT gunOffsetY = 10'd35;

    logic [lifeWidth-1:0] lifeCount;
    logic                 fired;
    posT                  bulletPos;
    posT                  gunPos;
    logic                 inFlight;

    assign gunPos.x = playerPos.x + gunOffsetX;
    assign gunPos.y = playerPos.y + gunOffsetY;

    // Keeps moving while alive and on screen
    assign inFlight = fired
        && (lifeCount < lifeWidth'(bulletLife))
        && (bulletPos.x < screenWidth);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            fired     <= 1'b0;
            lifeCount <= '0;
        end else if (!fired) begin
            fired     <= fire;    // Armed, waiting for the key
            lifeCount <= '0;
        end else if (inFlight) begin
            lifeCount <= lifeCount + 1'b1;
        end else begin
            fired     <= 1'b0;    // Re-arm
            lifeCount <= '0;
        end
    end

    // Follows the gun until it flies
    always_ff @(posedge clk) begin
        if (inFlight) begin
            bulletPos.x <= bulletPos.x + coordT'(bulletSpeed);
        end else begin
            bulletPos <= gunPos;
        end
    end

    assign bullet = '{pos: bulletPos, fired: fired};

endmodule

// File: source/missileUnit.sv
// One missile: phase FSM, leftward motion and explosion timer
// Bullet hit and player collision tests
module missileUnit
    import gamePkg::*;
#(
    parameter int missileSpeed = 10,
    parameter int explodeSteps = 15
) (
    input  logic         clk,
    input  logic         rstN,
    input  logic         start,
    input  logic         gameOver,
    input  logic         launch,
    input  logic         window,
    input  posT          playerPos,
    input  bulletStateT  bullet,
    output missileStateT missile,
    output logic         hitPlayer
);

    localparam int    countWidth  = $clog2(explodeSteps + 1);
    localparam coordT launchDropY = 10'd30;    // Below the player's top edge

    missilePhaseT          phase;
    missilePhaseT          phaseNext;
    posT                   pos;
    posT                   posNext;
    logic [countWidth-1:0] explodeCount;
    logic [countWidth-1:0] explodeCountNext;
    logic [10:0]           boxRight;
    logic [10:0]           boxBottom;
    logic [10:0]           playerRight;
    logic [10:0]           playerBottom;
    logic                  bulletHit;

    //////////////////////////////////////////////////////////////////////
    // Collision tests, all edges included
    //////////////////////////////////////////////////////////////////////
    assign boxRight     = {1'b0, pos.x} + {1'b0, missileWidth};
    assign boxBottom    = {1'b0, pos.y} + {1'b0, missileHeight};
    assign playerRight  = {1'b0, playerPos.x} + {1'b0, playerWidth};
    assign playerBottom = {1'b0, playerPos.y} + {1'b0, playerHeight};

    // Only a bullet in the air counts
    assign bulletHit = bullet.fired
        && (bullet.pos.x >= pos.x) && ({1'b0, bullet.pos.x} <= boxRight)
        && (bullet.pos.y >= pos.y) && ({1'b0, bullet.pos.y} <= boxBottom);

    assign hitPlayer = (phase == missileFlying)
        && (pos.x >= playerPos.x) && ({1'b0, pos.x} <= playerRight)
        && (pos.y >= playerPos.y) && ({1'b0, pos.y} <= playerBottom);

    //////////////////////////////////////////////////////////////////////
    // Phase FSM
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        phaseNext        = phase;
        posNext          = pos;
        explodeCountNext = explodeCount;
        if (!start || gameOver) begin
            phaseNext        = missileIdle;
            posNext          = '0;
            explodeCountNext = '0;
        end else if (launch) begin
            phaseNext        = missileFlying;
            posNext.x        = screenWidth;    // Enters at the right edge
            posNext.y        = playerPos.y + launchDropY;
            explodeCountNext = '0;
        end else if (window) begin
            case (phase)
                missileFlying: begin
                    if (bulletHit) begin
                        phaseNext = missileExploding;
                    end else begin
                        posNext.x = pos.x - coordT'(missileSpeed);
                    end
                end
                missileExploding: begin
                    explodeCountNext = explodeCount + 1'b1;
                    if (explodeCount == countWidth'(explodeSteps - 1)) begin
                        phaseNext = missileSpent;    // Last explosion frame
                    end
                end
                default: begin
                    phaseNext = phase;    // Idle and spent wait for launch
                end
            endcase
        end else begin
            phaseNext = missileIdle;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase        <= missileIdle;
            explodeCount <= '0;
        end else begin
            phase        <= phaseNext;
            explodeCount <= explodeCountNext;
        end
    end

    always_ff @(posedge clk) begin
        pos <= posNext;
    end

    assign missile = '{pos: pos, phase: phase};

endmodule

// File: source/pixelCompositor.sv
// Priority colouring of the scanned pixel with a registered output
// Player, bullet and missile boxes over sky, banners and blanking
module pixelCompositor
    import gamePkg::*;
(
    input  logic         clk,
    input  logic         rstN,
    input  posT          drawPos,
    input  logic         blank,
    input  logic         start,
    input  logic         gameOver,
    input  posT          playerPos,
    input  bulletStateT  bullet,
    input  missileStateT missileA,
    input  missileStateT missileB,
    output colorT        rgb
);

    colorT pixelColor;
    logic  onScreen;
    logic  bannerRow;
    logic  inPlayer;
    logic  inBullet;
    logic  inMissileA;
    logic  inMissileB;

    // Half-open box, left and top edges inside
    function automatic logic inBox(input posT pix, input posT org,
                                   input coordT w, input coordT h);
        logic [10:0] right;
        logic [10:0] bottom;
        right  = {1'b0, org.x} + {1'b0, w};
        bottom = {1'b0, org.y} + {1'b0, h};
        return (pix.x >= org.x) && ({1'b0, pix.x} < right)
            && (pix.y >= org.y) && ({1'b0, pix.y} < bottom);
    endfunction

    // Drawn only while flying or exploding
    function automatic logic missileShown(input missileStateT m, input posT pix);
        logic active;
        active = (m.phase == missileFlying) || (m.phase == missileExploding);
        return active && inBox(pix, m.pos, missileWidth, missileHeight);
    endfunction

    assign onScreen = blank && (drawPos.x < screenWidth) && (drawPos.y < screenHeight);
    assign bannerRow = (drawPos.y >= bannerTop) && (drawPos.y < bannerBottom);

    assign inPlayer   = inBox(drawPos, playerPos, playerWidth, playerHeight);
    assign inBullet   = bullet.fired && inBox(drawPos, bullet.pos, bulletSize, bulletSize);
    assign inMissileA = missileShown(missileA, drawPos);
    assign inMissileB = missileShown(missileB, drawPos);

    //////////////////////////////////////////////////////////////////////
    // Colour priority
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        if (!onScreen) begin
            pixelColor = blackColor;
        end else if (!start || gameOver) begin
            // Title or end screen, no sprites
            if (bannerRow) begin
                pixelColor = start ? endColor : startColor;
            end else begin
                pixelColor = skyColor;
            end
        end else if (inPlayer) begin
            pixelColor = playerColor;
        end else if (inBullet) begin
            pixelColor = bulletColor;
        end else if (inMissileA) begin
            pixelColor = (missileA.phase == missileExploding) ? explodeColor : missileColor;
        end else if (inMissileB) begin
            pixelColor = (missileB.phase == missileExploding) ? explodeColor : missileColor;
        end else begin
            pixelColor = skyColor;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rgb <= blackColor;
        end else begin
            rgb <= pixelColor;
        end
    end

endmodule

// File: source/gameTop.sv
// Top level of the shooter game logic
// Scroll control, bullet, two missiles and the pixel compositor
module gameTop
    import gamePkg::*;
#(
    parameter int scrollStep    = 4,
    parameter int scrollWrap    = 1280,
    parameter int missileWindow = 640,
    parameter int launchOffsetA = 0,
    parameter int launchOffsetB = 640,
    parameter int missileSpeed  = 10,
    parameter int explodeSteps  = 15,
    parameter int bulletSpeed   = 20,
    parameter int bulletLife    = 60
) (
    input  logic  clk,
    input  logic  rstN,
    input  posT   drawPos,
    input  logic  blank,       // High in the visible part of the scan
    input  logic  start,
    input  logic  fire,
    input  posT   playerPos,
    output colorT rgb
);

    logic         launchA;
    logic         launchB;
    logic         windowA;
    logic         windowB;
    logic         gameOver;
    logic         hitPlayerA;
    logic         hitPlayerB;
    bulletStateT  bulletState;
    missileStateT missileStateA;
    missileStateT missileStateB;

    gameControl #(
        .scrollStep   (scrollStep),
        .scrollWrap   (scrollWrap),
        .missileWindow(missileWindow),
        .launchOffsetA(launchOffsetA),
        .launchOffsetB(launchOffsetB)
    ) uControl (
        .clk, .rstN, .start,
        .hitPlayerA, .hitPlayerB,
        .launchA, .launchB,
        .windowA, .windowB,
        .gameOver
    );

    bulletUnit #(
        .bulletSpeed(bulletSpeed),
        .bulletLife (bulletLife)
    ) uBullet (
        .clk, .rstN, .fire, .playerPos,
        .bullet(bulletState)
    );

    // Missile A covers the first half of the scroll loop, B the second
    missileUnit #(
        .missileSpeed(missileSpeed),
        .explodeSteps(explodeSteps)
    ) missileA (
        .clk, .rstN, .start, .gameOver,
        .launch(launchA), .window(windowA),
        .playerPos, .bullet(bulletState),
        .missile(missileStateA), .hitPlayer(hitPlayerA)
    );

    missileUnit #(
        .missileSpeed(missileSpeed),
        .explodeSteps(explodeSteps)
    ) missileB (
        .clk, .rstN, .start, .gameOver,
        .launch(launchB), .window(windowB),
        .playerPos, .bullet(bulletState),
        .missile(missileStateB), .hitPlayer(hitPlayerB)
    );

    pixelCompositor uCompositor (
        .clk, .rstN, .drawPos, .blank, .start, .gameOver, .playerPos,
        .bullet  (bulletState),
        .missileA(missileStateA),
        .missileB(missileStateB),
        .rgb
    );

endmodule

// File: sim/gameTop_assert.sv
// Concurrent checks on the scroll offset range and the game-over flag
module gameTopAssert
    import gamePkg::*;
#(
    parameter int offsetLimit = 1284
) (
    input logic   clk,
    input logic   rstN,
    input logic   start,
    input logic   gameOver,
    input offsetT offset
);

    // Wrap is taken at most one step past the wrap value
    offsetInRange: assert property (@(posedge clk) disable iff (!rstN)
        offset <= offsetT'(offsetLimit))
        else $error("Scroll offset %0d is above its limit", offset);

    gameOverHeld: assert property (@(posedge clk) disable iff (!rstN)
        gameOver && start |=> gameOver)
        else $error("Game over dropped while start stayed high");

    gameOverCleared: assert property (@(posedge clk) disable iff (!rstN)
        !start |=> !gameOver)
        else $error("Game over still set one cycle after start went low");

endmodule

bind gameTop gameTopAssert #(
    .offsetLimit(scrollWrap + scrollStep)
) gameTopAssert_inst (
    .clk, .rstN, .start, .gameOver,
    .offset(uControl.offset)
);

// File: sim/gameTopTb.sv
// Testbench for gameTop with seeded random scan, fire, start and player moves
// Cycle model of scroll, bullet, missiles and pixel colour, checked every cycle
module gameTopTb
    import gamePkg::*;
();

    localparam int clkPeriod   = 100;
    localparam int resetCycles = 16;
    localparam int stimCycles  = 20000;

    logic  clk;
    logic  rstN;
    posT   drawPos;
    logic  blank;
    logic  start;
    logic  fire;
    posT   playerPos;
    colorT rgb;

    // Model state updated on each rising edge
    int           offset;
    logic         gameOver;
    logic         bulletFired;
    int           bulletLife;
    int           bulletX;
    int           bulletY;
    missilePhaseT missilePhase [2];
    int           missileX [2];
    int           missileY [2];
    int           explodeCount [2];
    logic [11:0]  expRgb;

    int checks;
    int errors;
    int explosions;
    int gameOvers;

    gameTop gameTop_inst (
        .clk, .rstN, .drawPos, .blank, .start, .fire, .playerPos, .rgb
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Closed box when edges count, half-open otherwise
    function automatic logic overlaps(input int px, input int py, input int ox, input int oy,
                                      input int w, input int h, input logic edges);
        if (edges) begin
            return px >= ox && px <= ox + w && py >= oy && py <= oy + h;
        end
        return px >= ox && px < ox + w && py >= oy && py < oy + h;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    // Lowest priority first so each later rule overrides
    function automatic logic [11:0] pixelModel();
        logic [11:0] color;
        int          dx;
        int          dy;
        dx    = int'(drawPos.x);
        dy    = int'(drawPos.y);
        color = 12'hDDB;
        for (int i = 1; i >= 0; i--) begin
            if ((missilePhase[i] == missileFlying || missilePhase[i] == missileExploding)
                    && overlaps(dx, dy, missileX[i], missileY[i], 100, 50, 1'b0)) begin
                color = (missilePhase[i] == missileExploding) ? 12'hF60 : 12'hCDD;
            end
        end
        if (bulletFired && overlaps(dx, dy, bulletX, bulletY, 5, 5, 1'b0)) begin
            color = 12'hFD0;
        end
        if (overlaps(dx, dy, int'(playerPos.x), int'(playerPos.y), 50, 100, 1'b0)) begin
            color = 12'hFEB;
        end
        if (!start || gameOver) begin
            color = (dy >= 100 && dy < 200) ? (start ? 12'h00F : 12'hF00) : 12'hDDB;
        end
        if (!blank || dx >= 640 || dy >= 480) begin
            color = 12'h000;
        end
        return color;
    endfunction

    task automatic stepModel();
        logic [11:0] pixel;
        logic        inFlight;
        logic        hitPlayer [2];
        logic        bulletHit [2];
        int          playerX;
        int          playerY;
        playerX = int'(playerPos.x);
        playerY = int'(playerPos.y);
        if (!rstN) begin
            offset      = 0;
            gameOver    = 1'b0;
            bulletFired = 1'b0;
            bulletLife  = 0;
            bulletX     = playerX + 20;
            bulletY     = playerY + 35;
            for (int i = 0; i < 2; i++) begin
                missilePhase[i] = missileIdle;
                explodeCount[i] = 0;
            end
            expRgb = 12'h000;
            return;
        end
        pixel    = pixelModel();
        inFlight = bulletFired && bulletLife < 60 && bulletX < 640;
        for (int i = 0; i < 2; i++) begin
            hitPlayer[i] = missilePhase[i] == missileFlying
                && overlaps(missileX[i], missileY[i], playerX, playerY, 50, 100, 1'b1);
            bulletHit[i] = bulletFired
                && overlaps(bulletX, bulletY, missileX[i], missileY[i], 100, 50, 1'b1);
        end
        for (int i = 0; i < 2; i++) begin
            if (!start || gameOver) begin
                missilePhase[i] = missileIdle;
                explodeCount[i] = 0;
            end else if (offset == i * 640) begin    // Launch point
                missilePhase[i] = missileFlying;
                missileX[i]     = 640;
                missileY[i]     = (playerY + 30) % 1024;
                explodeCount[i] = 0;
            end else if (offset < i * 640 || offset >= i * 640 + 640) begin
                missilePhase[i] = missileIdle;
            end else if (missilePhase[i] == missileFlying) begin
                if (bulletHit[i]) begin
                    missilePhase[i] = missileExploding;
                    explosions++;
                end else begin
                    missileX[i] = (missileX[i] + 1024 - 10) % 1024;    // 10-bit wrap
                end
            end else if (missilePhase[i] == missileExploding) begin
                if (explodeCount[i] == 14) begin
                    missilePhase[i] = missileSpent;
                end
                explodeCount[i]++;
            end
        end
        if (!bulletFired) begin
            bulletFired = fire;
            bulletLife  = 0;
        end else if (inFlight) begin
            bulletLife++;
        end else begin
            bulletFired = 1'b0;
            bulletLife  = 0;
        end
        if (inFlight) begin
            bulletX = (bulletX + 20) % 1024;
        end else begin
            bulletX = (playerX + 20) % 1024;
            bulletY = (playerY + 35) % 1024;
        end
        if (!start) begin
            gameOver = 1'b0;
        end else if (hitPlayer[0] || hitPlayer[1]) begin
            gameOvers += gameOver ? 0 : 1;
            gameOver  = 1'b1;
        end
        offset = (offset >= 1280) ? 0 : offset + 4;
        expRgb = pixel;
    endtask

    task automatic checkValue(input string name, input logic [11:0] expected,
                              input logic [11:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s at %0t: expected 0x%03h, got 0x%03h",
                     name, $time, expected, actual);
        end
    endtask

    // Bullets only in the first half of each 3000-cycle block, so missiles also reach the player
    task automatic driveInputs(input int cyc);
        logic fireWindow;
        fireWindow = (cyc % 3000) < 1500;
        drawPos <= '{x: 10'($urandom % 800), y: 10'($urandom % 525)};
        blank   <= ($urandom % 10) != 0;
        fire    <= fireWindow && (($urandom % 2) == 1);
        start   <= (cyc >= 2000) && !(cyc >= 6000 && (cyc % 6000) < 8);
        if (cyc % 3000 == 0) begin
            playerPos <= '{x: 10'($urandom % 590), y: 10'($urandom % 380)};
        end
    endtask

    always @(posedge clk) stepModel();

    always @(negedge clk) checkValue("rgb", expRgb, rgb);    // One cycle behind the inputs

    initial begin
        void'($urandom(23));
        rstN      <= 1'b0;
        drawPos   <= '0;
        blank     <= 1'b0;
        start     <= 1'b0;
        fire      <= 1'b0;
        playerPos <= '{x: 10'd100, y: 10'd200};
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        for (int cyc = 0; cyc < stimCycles; cyc++) begin
            driveInputs(cyc);
            @(posedge clk);
        end
        @(negedge clk);
        @(posedge clk);
        if (explosions == 0) begin
            $display("No missile was ever shot down");
        end
        if (gameOvers == 0) begin
            $display("The game never reached game over");
        end
        $display("checks %0d errors %0d explosions %0d gameOvers %0d",
                 checks, errors, explosions, gameOvers);
        if (errors == 0 && explosions > 0 && gameOvers > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((resetCycles + stimCycles + 200) * clkPeriod);
        $display("Timeout, the run did not finish in the expected time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: gameTop.f
source/gamePkg.sv
source/gameControl.sv
source/bulletUnit.sv
source/missileUnit.sv
source/pixelCompositor.sv
source/gameTop.sv
sim/gameTop_assert.sv
sim/gameTopTb.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator, run the testbench, look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module gameTopTb -f gameTop.f
output=$(./obj_dir/VgameTopTb 2>&1) || true
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -q "RESULT: PASS"; then
    exit 0
fi
exit 1
